// File: stmm_weight_load.f
source/stmm_pkg.sv
source/stmm_fetch.sv
source/sdram_burst_reader.sv
source/weight_line_bram.sv
source/quant_param_reg.sv
source/stmm_weight_load_top.sv
tests/sdram_avmm_model.sv
tests/tb_stmm_weight_load.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")"

build_dir=build
log_file=sim.log

verilator --binary --timing -Wno-fatal \
    -f stmm_weight_load.f \
    --top-module tb_stmm_weight_load \
    -Mdir "$build_dir" -o sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/sim" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "All checks passed" "$log_file"; then
    exit 0
else
    exit 1
fi

// File: tests/tb_stmm_weight_load.sv
`timescale 1ns/1ps
`default_nettype none

module tb_stmm_weight_load;

    import stmm_pkg::*;

    localparam int line_w      = 512;
    localparam int line_num    = 8;
    localparam int line_aw     = $clog2(line_num);
    localparam int blk_num     = line_w / sdram_w;
    localparam int line_stride = 16 * blk_num;
    localparam int mem_words   = 256;
    localparam int mem_aw      = $clog2(mem_words);
    localparam int mem_latency = 4;
    localparam int max_stall   = 32;
    localparam int clk_period  = 100;
    localparam int num_tests   = 5;

    // worst case per load with a factor of two for margin
    localparam int load_limit  = 2 * line_num * blk_num * (max_stall + mem_latency);
    localparam int watchdog_ns = num_tests * (load_limit + 200) * clk_period;

    logic               clk;
    logic               rst_n;
    logic               i_start;
    logic [addr_w-1:0]  i_fetch_addr;
    logic               i_rd_en;
    logic [line_aw-1:0] i_rd_addr;
    logic               stall_en;

    logic [addr_w-1:0]  avm_address;
    logic               avm_read;
    logic [burst_w-1:0] avm_burstcount;
    logic               avm_waitrequest;
    logic [sdram_w-1:0] avm_readdata;
    logic               avm_readdatavalid;

    logic [line_w-1:0]  o_rd_data;
    logic [15:0]        o_scale_fp16;
    logic signed [7:0]  o_z_x;
    logic signed [7:0]  o_z_w;
    logic signed [7:0]  o_zero;
    logic               o_quant_valid;
    logic               o_done;

    int value_errs;
    int other_errs;
    int proto_errs;

    stmm_weight_load_top #(
        .bram_w (line_w),
        .bram_l (line_num)
    ) dut_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_start             (i_start),
        .i_fetch_addr        (i_fetch_addr),
        .o_avm_address       (avm_address),
        .o_avm_read          (avm_read),
        .o_avm_burstcount    (avm_burstcount),
        .i_avm_waitrequest   (avm_waitrequest),
        .i_avm_readdata      (avm_readdata),
        .i_avm_readdatavalid (avm_readdatavalid),
        .i_rd_en             (i_rd_en),
        .i_rd_addr           (i_rd_addr),
        .o_rd_data           (o_rd_data),
        .o_scale_fp16        (o_scale_fp16),
        .o_z_x               (o_z_x),
        .o_z_w               (o_z_w),
        .o_zero              (o_zero),
        .o_quant_valid       (o_quant_valid),
        .o_done              (o_done)
    );

    sdram_avmm_model #(
        .mem_words   (mem_words),
        .blk_num     (blk_num),
        .mem_latency (mem_latency)
    ) model_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_stall_en      (stall_en),
        .i_address       (avm_address),
        .i_read          (avm_read),
        .i_burstcount    (avm_burstcount),
        .o_waitrequest   (avm_waitrequest),
        .o_readdata      (avm_readdata),
        .o_readdatavalid (avm_readdatavalid),
        .o_error_count   (proto_errs)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // expected values from the SDRAM model contents
    ////////////////////////////////////////////////////////////

    function automatic logic [sdram_w-1:0] model_word(input logic [addr_w-1:0] addr);
        return model_i.mem[addr[4 +: mem_aw]];
    endfunction

    // block 0 in the low bits
    function automatic logic [line_w-1:0] expected_line(input logic [addr_w-1:0] base,
                                                        input int k);
        logic [line_w-1:0] line;
        for (int b = 0; b < blk_num; b++) begin
            line[b*sdram_w +: sdram_w] = model_word(base + k * line_stride + 16 * b);
        end
        return line;
    endfunction

    // quant word follows the last line
    function automatic quant_fields_t expected_quant(input logic [addr_w-1:0] base);
        logic [sdram_w-1:0] w;
        quant_fields_t      q;
        w            = model_word(base + line_num * line_stride);
        q            = '0;
        q.z_x        = w[7:0];
        q.z_w        = w[39:32];
        q.zero       = w[71:64];
        q.scale_fp16 = w[111:96];
        return q;
    endfunction

    function automatic quant_fields_t dut_quant();
        quant_fields_t q;
        q            = '0;
        q.z_x        = o_z_x;
        q.z_w        = o_z_w;
        q.zero       = o_zero;
        q.scale_fp16 = o_scale_fp16;
        return q;
    endfunction

    ////////////////////////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////////////////////////

    task automatic check_line(input string name, input logic [line_w-1:0] exp,
                              input logic [line_w-1:0] act);
        if (act !== exp) begin
            $display("error %s: expected %h actual %h", name, exp, act);
            value_errs++;
        end
    endtask

    task automatic check_quant(input string name, input quant_fields_t exp,
                               input quant_fields_t act);
        string exp_s;
        string act_s;
        if (act !== exp) begin
            exp_s = $sformatf("scale %h z_x %h z_w %h zero %h",
                              exp.scale_fp16, exp.z_x, exp.z_w, exp.zero);
            act_s = $sformatf("scale %h z_x %h z_w %h zero %h",
                              act.scale_fp16, act.z_x, act.z_w, act.zero);
            $display("error %s: expected %s actual %s", name, exp_s, act_s);
            value_errs++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("error %s: expected %b actual %b", name, exp, act);
            value_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // drive helpers
    ////////////////////////////////////////////////////////////

    task automatic start_load(input logic [addr_w-1:0] addr);
        @(posedge clk);
        i_start      <= 1'b1;
        i_fetch_addr <= addr;
        @(posedge clk);
        i_start <= 1'b0;
    endtask

    task automatic wait_for_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!o_done && cycles < load_limit) begin
            @(negedge clk);
            cycles++;
        end
        if (!o_done) begin
            $display("%s: load did not finish within %0d cycles", name, load_limit);
            other_errs++;
        end
    endtask

    task automatic read_line(input int k, output logic [line_w-1:0] data);
        @(posedge clk);
        i_rd_en   <= 1'b1;
        i_rd_addr <= line_aw'(k);
        @(posedge clk);
        i_rd_en <= 1'b0;
        @(negedge clk);
        data = o_rd_data;
    endtask

    task automatic check_lines(input string name, input logic [addr_w-1:0] base);
        logic [line_w-1:0] data;
        for (int k = 0; k < line_num; k++) begin
            read_line(k, data);
            check_line(name, expected_line(base, k), data);
        end
    endtask

    task automatic check_load(input string name, input logic [addr_w-1:0] base);
        check_lines(name, base);
        check_quant(name, expected_quant(base), dut_quant());
        check_bit(name, 1'b1, o_quant_valid);
        check_bit(name, 1'b1, o_done);
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    // second start lands mid-load and must be dropped
    task automatic test_busy_start();
        string name = "busy_start";
        @(negedge clk);
        check_bit(name, 1'b1, o_done);
        start_load(32'h0000_0100);
        repeat (10) @(posedge clk);
        @(negedge clk);
        check_bit(name, 1'b0, o_done);
        start_load(32'h0000_0900);
        wait_for_done(name);
        check_load(name, 32'h0000_0100);
        repeat (4) @(negedge clk);
        check_bit(name, 1'b1, o_done);
    endtask

    task automatic test_full_load();
        string name = "full_load";
        start_load(32'h0000_0040);
        wait_for_done(name);
        check_lines(name, 32'h0000_0040);
    endtask

    task automatic test_quant_decode();
        string name = "quant_decode";
        start_load(32'h0000_0480);
        wait_for_done(name);
        check_quant(name, expected_quant(32'h0000_0480), dut_quant());
        check_bit(name, 1'b1, o_quant_valid);
    endtask

    task automatic test_stall_load();
        string name = "stall_load";
        @(posedge clk);
        stall_en <= 1'b1;
        start_load(32'h0000_0200);
        wait_for_done(name);
        check_load(name, 32'h0000_0200);
        @(posedge clk);
        stall_en <= 1'b0;
    endtask

    task automatic test_reload();
        string name = "reload";
        start_load(32'h0000_0600);
        @(negedge clk);
        check_bit(name, 1'b0, o_quant_valid);
        check_bit(name, 1'b0, o_done);
        wait_for_done(name);
        check_load(name, 32'h0000_0600);
    endtask

    initial begin
        rst_n        = 1'b0;
        i_start      = 1'b0;
        i_fetch_addr = '0;
        i_rd_en      = 1'b0;
        i_rd_addr    = '0;
        stall_en     = 1'b0;
        value_errs   = 0;
        other_errs   = 0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        test_busy_start();
        test_full_load();
        test_quant_decode();
        test_stall_load();
        test_reload();

        repeat (4) @(posedge clk);
        $display("value errors %0d, other errors %0d, protocol errors %0d",
                 value_errs, other_errs, proto_errs);
        if (value_errs + other_errs + proto_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/sdram_avmm_model.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_avmm_model #(
    parameter int mem_words   = 256,
    parameter int blk_num     = 4,
    parameter int mem_latency = 4
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_stall_en,
    input  logic [stmm_pkg::addr_w-1:0]   i_address,
    input  logic                          i_read,
    input  logic [stmm_pkg::burst_w-1:0]  i_burstcount,
    output logic                          o_waitrequest,
    output logic [stmm_pkg::sdram_w-1:0]  o_readdata,
    output logic                          o_readdatavalid,
    output int                            o_error_count
);

    import stmm_pkg::*;

    localparam int mem_aw = $clog2(mem_words);

    logic [sdram_w-1:0] mem [mem_words];

    logic [31:0]        fill_state;
    logic [31:0]        stall_state;
    logic [mem_aw-1:0]  rd_word;
    logic [burst_w-1:0] beats_left;
    int                 lat_cnt;
    logic               hold_pend;
    logic [addr_w-1:0]  hold_addr;
    logic [burst_w-1:0] hold_cnt;

    // galois form with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // one lfsr step per stored bit
    initial begin
        fill_state = 32'hca3e;
        for (int w = 0; w < mem_words; w++) begin
            for (int b = 0; b < sdram_w; b++) begin
                mem[w][b]  = fill_state[0];
                fill_state = lfsr_next(fill_state);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // command accept, fixed latency, beat return
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_state     <= 32'hca3e;
            o_waitrequest   <= 1'b0;
            o_readdata      <= '0;
            o_readdatavalid <= 1'b0;
            rd_word         <= '0;
            beats_left      <= '0;
            lat_cnt         <= 0;
            hold_pend       <= 1'b0;
            hold_addr       <= '0;
            hold_cnt        <= '0;
            o_error_count   <= 0;
        end else begin
            stall_state     <= lfsr_next(stall_state);
            o_waitrequest   <= i_stall_en && stall_state[0];
            o_readdatavalid <= 1'b0;

            // command must not move while stalled
            if (hold_pend && (!i_read || i_address != hold_addr
                              || i_burstcount != hold_cnt)) begin
                $display("protocol failure: command changed while waitrequest was high");
                o_error_count <= o_error_count + 1;
            end
            hold_pend <= o_waitrequest && i_read;
            hold_addr <= i_address;
            hold_cnt  <= i_burstcount;

            if (i_read && !o_waitrequest) begin
                if (i_burstcount != burst_w'(blk_num) && i_burstcount != burst_w'(1)) begin
                    $display("protocol failure: burst count %0d is neither a line nor one word",
                             i_burstcount);
                    o_error_count <= o_error_count + 1;
                end
                rd_word    <= i_address[4 +: mem_aw];
                beats_left <= i_burstcount;
                lat_cnt    <= mem_latency - 1;
            end else if (beats_left != '0) begin
                if (lat_cnt != 0) begin
                    lat_cnt <= lat_cnt - 1;
                end else begin
                    o_readdatavalid <= 1'b1;
                    o_readdata      <= mem[rd_word];
                    rd_word         <= rd_word + 1'b1;
                    beats_left      <= beats_left - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/stmm_weight_load_top.sv
`timescale 1ns/1ps
`default_nettype none

module stmm_weight_load_top #(
    parameter int bram_w = 1408,
    parameter int bram_l = 176
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_start,
    input  logic [stmm_pkg::addr_w-1:0]   i_fetch_addr,
    output logic [stmm_pkg::addr_w-1:0]   o_avm_address,
    output logic                          o_avm_read,
    output logic [stmm_pkg::burst_w-1:0]  o_avm_burstcount,
    input  logic                          i_avm_waitrequest,
    input  logic [stmm_pkg::sdram_w-1:0]  i_avm_readdata,
    input  logic                          i_avm_readdatavalid,
    input  logic                          i_rd_en,
    input  logic [$clog2(bram_l)-1:0]     i_rd_addr,
    output logic [bram_w-1:0]             o_rd_data,
    output logic [15:0]                   o_scale_fp16,
    output logic signed [7:0]             o_z_x,
    output logic signed [7:0]             o_z_w,
    output logic signed [7:0]             o_zero,
    output logic                          o_quant_valid,
    output logic                          o_done
);

    import stmm_pkg::*;

    // fetch <-> reader
    logic               read_start;
    logic [addr_w-1:0]  read_addr;
    logic [burst_w-1:0] read_cnt;
    logic               read_valid;
    sdram_word_t        read_data;
    logic               read_done;

    // fetch -> bram / quant regs
    logic                      bram_we;
    logic [$clog2(bram_l)-1:0] bram_waddr;
    logic [bram_w-1:0]         bram_wdata;
    logic                      quant_load;
    logic                      start_accepted;

    stmm_fetch #(
        .bram_w (bram_w),
        .bram_l (bram_l)
    ) fetch_i (
        .clk              (clk),
        .rst_n            (rst_n),
        .i_start          (i_start),
        .i_fetch_addr     (i_fetch_addr),
        .i_read_valid     (read_valid),
        .i_read_data      (read_data),
        .i_read_done      (read_done),
        .o_read_start     (read_start),
        .o_read_addr      (read_addr),
        .o_read_cnt       (read_cnt),
        .o_bram_we        (bram_we),
        .o_bram_waddr     (bram_waddr),
        .o_bram_wdata     (bram_wdata),
        .o_quant_load     (quant_load),
        .o_start_accepted (start_accepted),
        .o_done           (o_done)
    );

    sdram_burst_reader reader_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .i_read_start        (read_start),
        .i_read_addr         (read_addr),
        .i_read_cnt          (read_cnt),
        .i_avm_waitrequest   (i_avm_waitrequest),
        .i_avm_readdata      (i_avm_readdata),
        .i_avm_readdatavalid (i_avm_readdatavalid),
        .o_avm_address       (o_avm_address),
        .o_avm_read          (o_avm_read),
        .o_avm_burstcount    (o_avm_burstcount),
        .o_read_valid        (read_valid),
        .o_read_data         (read_data),
        .o_read_done         (read_done)
    );

    weight_line_bram #(
        .bram_w (bram_w),
        .bram_l (bram_l)
    ) bram_i (
        .clk       (clk),
        .i_we      (bram_we),
        .i_waddr   (bram_waddr),
        .i_wdata   (bram_wdata),
        .i_rd_en   (i_rd_en),
        .i_rd_addr (i_rd_addr),
        .o_rd_data (o_rd_data)
    );

    // accepted start invalidates the held parameters
    quant_param_reg quant_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .i_load        (quant_load),
        .i_clear       (start_accepted),
        .i_word        (read_data),
        .o_scale_fp16  (o_scale_fp16),
        .o_z_x         (o_z_x),
        .o_z_w         (o_z_w),
        .o_zero        (o_zero),
        .o_quant_valid (o_quant_valid)
    );

endmodule

`default_nettype wire

// File: source/quant_param_reg.sv
`timescale 1ns/1ps
`default_nettype none

module quant_param_reg (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_load,
    input  logic                   i_clear,
    input  stmm_pkg::sdram_word_t  i_word,
    output logic [15:0]            o_scale_fp16,
    output logic signed [7:0]      o_z_x,
    output logic signed [7:0]      o_z_w,
    output logic signed [7:0]      o_zero,
    output logic                   o_quant_valid
);

    // field capture from the quant view of the beat
    always_ff @(posedge clk) begin
        if (i_load) begin
            o_scale_fp16 <= i_word.quant.scale_fp16;
            o_z_x        <= i_word.quant.z_x;
            o_z_w        <= i_word.quant.z_w;
            o_zero       <= i_word.quant.zero;
        end
    end

    // dropped when a new load starts and set once the record arrives
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_quant_valid <= 1'b0;
        end else if (i_clear) begin
            o_quant_valid <= 1'b0;
        end else if (i_load) begin
            o_quant_valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: source/weight_line_bram.sv
`timescale 1ns/1ps
`default_nettype none

module weight_line_bram #(
    parameter int bram_w = 1408,
    parameter int bram_l = 176
) (
    input  logic                       clk,
    input  logic                       i_we,
    input  logic [$clog2(bram_l)-1:0]  i_waddr,
    input  logic [bram_w-1:0]          i_wdata,
    input  logic                       i_rd_en,
    input  logic [$clog2(bram_l)-1:0]  i_rd_addr,
    output logic [bram_w-1:0]          o_rd_data
);

    // one full weight line per entry
    logic [bram_w-1:0] mem [bram_l];

    ////////////////////////////////////////////////////////////
    // write port
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // read port
    ////////////////////////////////////////////////////////////

    // data appears one cycle after rd_en
    always_ff @(posedge clk) begin
        if (i_rd_en) begin
            o_rd_data <= mem[i_rd_addr];
        end
    end

endmodule

`default_nettype wire

// File: source/sdram_burst_reader.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_burst_reader (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_read_start,
    input  logic [stmm_pkg::addr_w-1:0]   i_read_addr,
    input  logic [stmm_pkg::burst_w-1:0]  i_read_cnt,
    input  logic                          i_avm_waitrequest,
    input  logic [stmm_pkg::sdram_w-1:0]  i_avm_readdata,
    input  logic                          i_avm_readdatavalid,
    output logic [stmm_pkg::addr_w-1:0]   o_avm_address,
    output logic                          o_avm_read,
    output logic [stmm_pkg::burst_w-1:0]  o_avm_burstcount,
    output logic                          o_read_valid,
    output stmm_pkg::sdram_word_t         o_read_data,
    output logic                          o_read_done
);

    import stmm_pkg::*;

    // beats still owed by the slave for the current burst
    logic [burst_w-1:0] beats_left;
    logic               last_beat;

    ////////////////////////////////////////////////////////////
    // command phase
    ////////////////////////////////////////////////////////////

    // held stable while waitrequest is high
    always_ff @(posedge clk) begin
        if (i_read_start) begin
            o_avm_address    <= i_read_addr;
            o_avm_burstcount <= i_read_cnt;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_avm_read <= 1'b0;
        end else if (i_read_start) begin
            o_avm_read <= 1'b1;
        end else if (!i_avm_waitrequest) begin
            o_avm_read <= 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // response phase
    ////////////////////////////////////////////////////////////

    // returned beats cannot be stalled so they pass straight through
    assign o_read_valid = i_avm_readdatavalid && (beats_left != '0);
    assign o_read_data  = i_avm_readdata;
    assign last_beat    = o_read_valid && (beats_left == burst_w'(1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beats_left <= '0;
        end else if (i_read_start) begin
            beats_left <= i_read_cnt;
        end else if (o_read_valid) begin
            beats_left <= beats_left - 1'b1;
        end
    end

    // one cycle after the final beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_read_done <= 1'b0;
        end else begin
            o_read_done <= last_beat;
        end
    end

endmodule

`default_nettype wire

// File: source/stmm_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module stmm_fetch #(
    parameter int bram_w = 1408,
    parameter int bram_l = 176
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          i_start,
    input  logic [stmm_pkg::addr_w-1:0]   i_fetch_addr,
    input  logic                          i_read_valid,
    input  stmm_pkg::sdram_word_t         i_read_data,
    input  logic                          i_read_done,
    output logic                          o_read_start,
    output logic [stmm_pkg::addr_w-1:0]   o_read_addr,
    output logic [stmm_pkg::burst_w-1:0]  o_read_cnt,
    output logic                          o_bram_we,
    output logic [$clog2(bram_l)-1:0]     o_bram_waddr,
    output logic [bram_w-1:0]             o_bram_wdata,
    output logic                          o_quant_load,
    output logic                          o_start_accepted,
    output logic                          o_done
);

    import stmm_pkg::*;

    localparam int blk_num     = bram_w / sdram_w;
    localparam int line_stride = 16 * blk_num;
    localparam int blk_cw      = (blk_num > 1) ? $clog2(blk_num) : 1;
    localparam int line_aw     = $clog2(bram_l);

    localparam logic [line_aw-1:0] last_line = line_aw'(bram_l - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_line_addr,
        st_line_recv,
        st_quant_addr,
        st_quant_recv
    } state_t;

    state_t state;
    state_t nxt_state;

    logic              blk_store;
    logic [blk_cw-1:0] blk_cnt;
    logic [bram_w-1:0] line_buf;

    assign o_done           = (state == st_idle);
    assign o_start_accepted = i_start && (state == st_idle);
    assign o_bram_wdata     = line_buf;

    ////////////////////////////////////////////////////////////
    // SDRAM and BRAM address counters
    ////////////////////////////////////////////////////////////

    // after the last line the SDRAM address already points at the quant word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_read_addr  <= '0;
            o_bram_waddr <= '0;
        end else if (o_start_accepted) begin
            o_read_addr  <= i_fetch_addr;
            o_bram_waddr <= '0;
        end else if (o_bram_we) begin
            o_read_addr  <= o_read_addr + addr_w'(line_stride);
            o_bram_waddr <= o_bram_waddr + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // line buffer and block counter
    ////////////////////////////////////////////////////////////

    // block 0 lands in the low bits
    always_ff @(posedge clk) begin
        if (blk_store) begin
            line_buf[blk_cnt * sdram_w +: sdram_w] <= i_read_data.raw;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_cnt <= '0;
        end else if (o_start_accepted || o_bram_we) begin
            blk_cnt <= '0;
        end else if (blk_store) begin
            blk_cnt <= blk_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // state machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= nxt_state;
        end
    end

    always_comb begin
        nxt_state    = state;
        o_read_start = 1'b0;
        o_read_cnt   = burst_w'(blk_num);
        blk_store    = 1'b0;
        o_bram_we    = 1'b0;
        o_quant_load = 1'b0;

        case (state)
            st_idle: begin
                if (i_start) begin
                    nxt_state = st_line_addr;
                end
            end

            st_line_addr: begin
                o_read_start = 1'b1;
                nxt_state    = st_line_recv;
            end

            st_line_recv: begin
                blk_store = i_read_valid;
                // read_done trails the last beat by one cycle
                if (i_read_done) begin
                    o_bram_we = 1'b1;
                    if (o_bram_waddr == last_line) begin
                        nxt_state = st_quant_addr;
                    end else begin
                        nxt_state = st_line_addr;
                    end
                end
            end

            st_quant_addr: begin
                // single-beat burst for the quant record
                o_read_cnt   = burst_w'(1);
                o_read_start = 1'b1;
                nxt_state    = st_quant_recv;
            end

            st_quant_recv: begin
                if (i_read_valid) begin
                    o_quant_load = 1'b1;
                    nxt_state    = st_idle;
                end
            end

            default: begin
                nxt_state = st_idle;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/stmm_pkg.sv
`default_nettype none

package stmm_pkg;

    // SDRAM bus geometry
    localparam int sdram_w = 128;
    localparam int addr_w  = 32;
    localparam int burst_w = 11;

    ////////////////////////////////////////////////////////////
    // quantization word layout
    ////////////////////////////////////////////////////////////

    // four 32-bit lanes with lane 0 at the low end
    typedef struct packed {
        logic [15:0]        rsvd_3;
        logic [15:0]        scale_fp16;
        logic [23:0]        rsvd_2;
        logic signed [7:0]  zero;
        logic [23:0]        rsvd_1;
        logic signed [7:0]  z_w;
        logic [23:0]        rsvd_0;
        logic signed [7:0]  z_x;
    } quant_fields_t;

    // one SDRAM beat seen as weight bits or as the quant record
    typedef union packed {
        logic [sdram_w-1:0] raw;
        quant_fields_t      quant;
    } sdram_word_t;

endpackage

`default_nettype wire
